//--- src.f
+incdir+.
ooo_pkg.sv
credit_fifo.sv
rename_map.sv
reorder_buffer.sv
arch_reg_file.sv
ooo_backend_top.sv
ooo_backend_sva.sv
tb_ooo_backend.sv

//--- tb_ooo_backend.sv
`default_nettype none

`include "ooo_cfg.svh"

module tb_ooo_backend;

    timeunit 1ns;
    timeprecision 100ps;

    import ooo_pkg::*;

    localparam int          N_INSTR    = 150;
    localparam int          Q_DEPTH    = `OOO_Q_DEPTH;
    localparam int          ROB_DEPTH  = `OOO_ROB_DEPTH;
    localparam int          WAIT_LIMIT = 2000;
    localparam logic [31:0] PC_BASE    = 32'h0000_1000;

    logic                      clk;
    logic                      rstn;
    logic                      disp_valid;
    xword_t                    disp_pc;
    arch_reg_t                 disp_arch;
    logic                      disp_has_dest;
    logic                      disp_credit;
    logic                      cmp_valid;
    rob_tag_t                  cmp_tag;
    xword_t                    cmp_data;
    logic                      cmp_credit;
    logic                      retire0_valid;
    xword_t                    retire0_pc;
    arch_reg_t                 retire0_arch;
    xword_t                    retire0_data;
    logic                      retire0_wr;
    logic                      retire1_valid;
    xword_t                    retire1_pc;
    arch_reg_t                 retire1_arch;
    xword_t                    retire1_data;
    logic                      retire1_wr;
    logic [`OOO_PHYS_REGS-1:0] phys_ready;
    arch_reg_t                 rd_reg;
    xword_t                    rd_data;

    // per instruction stimulus, drawn once from the seed
    arch_reg_t  arch_a [N_INSTR];
    logic       dest_a [N_INSTR];
    xword_t     data_a [N_INSTR];
    xword_t     model_arf [`OOO_ARCH_REGS];

    integer     seed = 32'h4ed2_687f;
    int         disp_sent;
    int         disp_ret;      // credit pulses seen
    int         cmp_sent;
    int         cmp_ret;
    int         ret_count;
    int         mon_errors;
    int         run_errors;

    ooo_backend_top UUT (.*);

    bind ooo_backend_top ooo_backend_sva u_sva (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic xword_t pc_of(input int i);
        return PC_BASE + xword_t'(i) * 4;
    endfunction

    function automatic bit word_differs(input string name, input logic [31:0] got,
                                        input logic [31:0] exp);
        if (got !== exp)
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        return got !== exp;
    endfunction

    // next retirement must be the next instruction in dispatch order
    task automatic check_retire(input xword_t pc, input arch_reg_t arch, input xword_t data,
                                input logic wr, input string slot);
        int k;
        k = ret_count;
        if (k >= N_INSTR) begin
            $display("%s retired more instructions than were dispatched", slot);
            mon_errors++;
            return;
        end
        if (word_differs({slot, "_pc"}, pc, pc_of(k)))
            mon_errors++;
        if (word_differs({slot, "_arch"}, arch, arch_a[k]))
            mon_errors++;
        if (word_differs({slot, "_data"}, data, data_a[k]))
            mon_errors++;
        if (word_differs({slot, "_wr"}, wr, dest_a[k]))
            mon_errors++;
        if (dest_a[k])
            model_arf[arch_a[k]] = data_a[k];
        ret_count++;
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!rstn) begin
            foreach (model_arf[r])
                model_arf[r] = '0;
        end else begin
            disp_ret = disp_ret + int'(disp_credit);
            cmp_ret  = cmp_ret + int'(cmp_credit);
            if (retire0_valid)
                check_retire(retire0_pc, retire0_arch, retire0_data, retire0_wr, "retire0");
            if (retire1_valid)  // slot 1 is the younger one
                check_retire(retire1_pc, retire1_arch, retire1_data, retire1_wr, "retire1");
        end
    end

    task automatic send_dispatches();
        int waited;
        for (int i = 0; i < N_INSTR; i++) begin
            waited = 0;
            @(posedge clk);
            #1;
            while (disp_sent - disp_ret >= Q_DEPTH) begin
                disp_valid = 1'b0;
                if (waited == WAIT_LIMIT) begin
                    $display("no dispatch credit came back for instruction %0d", i);
                    run_errors++;
                    return;
                end
                waited++;
                @(posedge clk);
                #1;
            end
            disp_valid    = 1'b1;
            disp_pc       = pc_of(i);
            disp_arch     = arch_a[i];
            disp_has_dest = dest_a[i];
            disp_sent++;
        end
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
    endtask

    task automatic send_completions();
        int avail[$];
        int next_alloc;
        int k;
        int idx;
        int idle;
        bit holding;
        next_alloc = 0;
        idle       = 0;
        holding    = 1'b1;
        while (cmp_sent < N_INSTR) begin
            @(posedge clk);
            #1;
            cmp_valid = 1'b0;
            // popped from the dispatch queue once its credit is back
            while (next_alloc < disp_ret) begin
                if (next_alloc != 0)
                    avail.push_back(next_alloc);
                next_alloc++;
            end
            // oldest held until the rob or the free list runs out of room
            if (holding && (disp_ret >= ROB_DEPTH || !UUT.free_avail)) begin
                if (ret_count != 0) begin
                    $display("instructions retired while the oldest was incomplete");
                    run_errors++;
                end
                avail.push_back(0);
                holding = 1'b0;
            end
            if (avail.size() != 0 && cmp_sent - cmp_ret < Q_DEPTH) begin
                k   = $unsigned($random(seed)) % avail.size();
                idx = avail[k];
                avail.delete(k);
                cmp_valid = 1'b1;
                cmp_tag   = rob_tag_t'(idx % ROB_DEPTH);  // slot from dispatch order
                cmp_data  = data_a[idx];
                cmp_sent++;
                idle = 0;
            end else if (idle == WAIT_LIMIT) begin
                $display("completions stalled with %0d of %0d sent", cmp_sent, N_INSTR);
                run_errors++;
                return;
            end else begin
                idle++;
            end
        end
        @(posedge clk);
        #1;
        cmp_valid = 1'b0;
    endtask

    initial begin
        int waited;
        rstn          = 1'b0;
        disp_valid    = 1'b0;
        disp_pc       = '0;
        disp_arch     = '0;
        disp_has_dest = 1'b0;
        cmp_valid     = 1'b0;
        cmp_tag       = '0;
        cmp_data      = '0;
        rd_reg        = '0;
        for (int i = 0; i < N_INSTR; i++) begin
            arch_a[i] = arch_reg_t'($random(seed));
            dest_a[i] = ($unsigned($random(seed)) % 5) != 0;  // about one in five without
            data_a[i] = $random(seed);
        end
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        if (word_differs("reset outputs", {disp_credit, cmp_credit, retire0_valid,
                                           retire1_valid, retire0_wr, retire1_wr}, '0))
            run_errors++;

        fork
            send_dispatches();
            send_completions();
        join_none

        waited = 0;
        while (ret_count < N_INSTR && waited < 4 * WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (ret_count < N_INSTR) begin
            $display("timed out with %0d of %0d instructions retired", ret_count, N_INSTR);
            run_errors++;
        end

        // last credits and ready bits land a little after the last retire
        waited = 0;
        while (!(disp_ret == N_INSTR && cmp_ret == N_INSTR && &phys_ready)
               && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (word_differs("disp_credit pulses", disp_ret, N_INSTR))
            run_errors++;
        if (word_differs("cmp_credit pulses", cmp_ret, N_INSTR))
            run_errors++;
        if (!(&phys_ready)) begin
            $display("MISMATCH phys_ready: got %h expected %h", phys_ready, {64{1'b1}});
            run_errors++;
        end

        for (int r = 0; r < `OOO_ARCH_REGS; r++) begin
            @(posedge clk);
            #1;
            rd_reg = arch_reg_t'(r);
            @(negedge clk);
            if (word_differs($sformatf("rd_data r%0d", r), rd_data, model_arf[r]))
                run_errors++;
        end

        $display("errors: retire %0d, run %0d, assertions %0d",
                 mon_errors, run_errors, UUT.u_sva.err_count);
        if (mon_errors + run_errors + UUT.u_sva.err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ooo_backend_sva.sv
`default_nettype none

`include "ooo_cfg.svh"

module ooo_backend_sva (
    input wire logic            clk,
    input wire logic            rstn,
    input wire logic            disp_valid,
    input wire logic            disp_credit,
    input wire logic            disp_pop,
    input wire logic            cmp_valid,
    input wire logic            cmp_credit,
    input wire logic            cmp_q_valid,
    input wire logic            retire0_valid,
    input wire logic            retire0_wr,
    input wire ooo_pkg::xword_t retire0_pc,
    input wire logic            retire1_valid,
    input wire logic            retire1_wr,
    input wire ooo_pkg::xword_t retire1_pc
);

    timeunit 1ns;
    timeprecision 100ps;

    import ooo_pkg::*;

    localparam int     Q_DEPTH = `OOO_Q_DEPTH;
    localparam xword_t PC_STEP = 32'd4;    // sequential word pcs

    int     err_count = 0;
    int     disp_cred;
    int     cmp_cred;
    xword_t last_pc;
    logic   seen_retire;

    // sender side credit counts, mirrored from the channels
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            disp_cred   <= Q_DEPTH;
            cmp_cred    <= Q_DEPTH;
            seen_retire <= 1'b0;
        end else begin
            disp_cred <= disp_cred + int'(disp_credit) - int'(disp_valid);
            cmp_cred  <= cmp_cred + int'(cmp_credit) - int'(cmp_valid);
            if (retire0_valid)
                seen_retire <= 1'b1;
        end
    end

    // youngest retired pc so far
    always_ff @(posedge clk) begin
        if (retire1_valid)
            last_pc <= retire1_pc;
        else if (retire0_valid)
            last_pc <= retire0_pc;
    end

    a_credit_use: assert property (@(posedge clk) disable iff (!rstn)
        (disp_valid -> disp_cred > 0) && (cmp_valid -> cmp_cred > 0)
        && disp_cred <= Q_DEPTH && cmp_cred <= Q_DEPTH)
        else begin
            $error("credit count out of range or valid sent without credit");
            err_count++;
        end

    // exactly one pulse per popped entry
    a_credit_return: assert property (@(posedge clk) disable iff (!rstn)
        disp_credit == $past(disp_pop) && cmp_credit == $past(cmp_q_valid))
        else begin
            $error("credit pulse does not follow a queue pop");
            err_count++;
        end

    a_slot1_order: assert property (@(posedge clk) disable iff (!rstn)
        retire1_valid |-> retire0_valid && retire1_pc == retire0_pc + PC_STEP)
        else begin
            $error("retire slot 1 without slot 0 or out of order");
            err_count++;
        end

    a_in_order: assert property (@(posedge clk) disable iff (!rstn)
        retire0_valid && seen_retire |-> retire0_pc == last_pc + PC_STEP)
        else begin
            $error("retired pc skips or repeats an instruction");
            err_count++;
        end

    a_wr_valid: assert property (@(posedge clk) disable iff (!rstn)
        (retire0_wr -> retire0_valid) && (retire1_wr -> retire1_valid))
        else begin
            $error("register write without a retirement");
            err_count++;
        end

endmodule

`default_nettype wire

//--- ooo_backend_top.sv
`default_nettype none

`include "ooo_cfg.svh"

module ooo_backend_top (
    input  wire logic               clk,
    input  wire logic               rstn,
    // dispatch channel
    input  wire logic               disp_valid,
    input  wire ooo_pkg::xword_t    disp_pc,
    input  wire ooo_pkg::arch_reg_t disp_arch,
    input  wire logic               disp_has_dest,
    output logic                    disp_credit,
    // completion channel
    input  wire logic               cmp_valid,
    input  wire ooo_pkg::rob_tag_t  cmp_tag,
    input  wire ooo_pkg::xword_t    cmp_data,
    output logic                    cmp_credit,
    // retirement
    output logic                    retire0_valid,
    output ooo_pkg::xword_t         retire0_pc,
    output ooo_pkg::arch_reg_t      retire0_arch,
    output ooo_pkg::xword_t         retire0_data,
    output logic                    retire0_wr,
    output logic                    retire1_valid,
    output ooo_pkg::xword_t         retire1_pc,
    output ooo_pkg::arch_reg_t      retire1_arch,
    output ooo_pkg::xword_t         retire1_data,
    output logic                    retire1_wr,
    output logic [`OOO_PHYS_REGS-1:0] phys_ready,
    // arch file read port
    input  wire ooo_pkg::arch_reg_t rd_reg,
    output ooo_pkg::xword_t         rd_data
);

    import ooo_pkg::*;

    dispatch_pl_t   disp_in;
    dispatch_pl_t   disp_head;
    complete_pl_t   cmp_in;
    complete_pl_t   cmp_head;
    logic           disp_q_valid;
    logic           cmp_q_valid;
    logic           disp_pop;
    logic           rob_space;
    logic           free_avail;
    phys_reg_t      new_phys;
    phys_reg_t      old_phys;
    phys_reg_t      ret0_old_phys;
    phys_reg_t      ret1_old_phys;

    assign disp_in = '{pc: disp_pc, arch: disp_arch, has_dest: disp_has_dest};
    assign cmp_in  = '{tag: cmp_tag, data: cmp_data};

    // stall dispatch on a full rob or an empty free list
    assign disp_pop = disp_q_valid && rob_space && free_avail;

    credit_fifo #(
        .payload_t (dispatch_pl_t),
        .DEPTH     (`OOO_Q_DEPTH)
    ) u_disp_q (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (disp_valid),
        .in_data   (disp_in),
        .out_valid (disp_q_valid),
        .out_data  (disp_head),
        .pop       (disp_pop),
        .credit    (disp_credit)
    );

    // completions drain every cycle
    credit_fifo #(
        .payload_t (complete_pl_t),
        .DEPTH     (`OOO_Q_DEPTH)
    ) u_cmp_q (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (cmp_valid),
        .in_data   (cmp_in),
        .out_valid (cmp_q_valid),
        .out_data  (cmp_head),
        .pop       (cmp_q_valid),
        .credit    (cmp_credit)
    );

    rename_map u_rename (
        .clk            (clk),
        .rstn           (rstn),
        .alloc          (disp_pop),
        .alloc_arch     (disp_head.arch),
        .alloc_has_dest (disp_head.has_dest),
        .free_avail     (free_avail),
        .new_phys       (new_phys),
        .old_phys       (old_phys),
        .release0_valid (retire0_wr),        // only has_dest entries free a reg
        .release0_phys  (ret0_old_phys),
        .release1_valid (retire1_wr),
        .release1_phys  (ret1_old_phys)
    );

    reorder_buffer u_rob (
        .clk              (clk),
        .rstn             (rstn),
        .alloc            (disp_pop),
        .alloc_pc         (disp_head.pc),
        .alloc_arch       (disp_head.arch),
        .alloc_has_dest   (disp_head.has_dest),
        .alloc_new_phys   (new_phys),
        .alloc_old_phys   (old_phys),
        .rob_space        (rob_space),
        .cmp_valid        (cmp_q_valid),
        .cmp_tag          (cmp_head.tag),
        .cmp_data         (cmp_head.data),
        .retire0_valid    (retire0_valid),
        .retire0_pc       (retire0_pc),
        .retire0_arch     (retire0_arch),
        .retire0_data     (retire0_data),
        .retire0_wr       (retire0_wr),
        .retire0_new_phys (),
        .retire0_old_phys (ret0_old_phys),
        .retire1_valid    (retire1_valid),
        .retire1_pc       (retire1_pc),
        .retire1_arch     (retire1_arch),
        .retire1_data     (retire1_data),
        .retire1_wr       (retire1_wr),
        .retire1_new_phys (),
        .retire1_old_phys (ret1_old_phys),
        .phys_ready       (phys_ready)
    );

    arch_reg_file u_arf (
        .clk      (clk),
        .rstn     (rstn),
        .wr0_en   (retire0_wr),
        .wr0_reg  (retire0_arch),
        .wr0_data (retire0_data),
        .wr1_en   (retire1_wr),
        .wr1_reg  (retire1_arch),
        .wr1_data (retire1_data),
        .rd_reg   (rd_reg),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

//--- arch_reg_file.sv
`default_nettype none

`include "ooo_cfg.svh"

module arch_reg_file (
    input  wire logic               clk,
    input  wire logic               rstn,
    input  wire logic               wr0_en,
    input  wire ooo_pkg::arch_reg_t wr0_reg,
    input  wire ooo_pkg::xword_t    wr0_data,
    input  wire logic               wr1_en,
    input  wire ooo_pkg::arch_reg_t wr1_reg,
    input  wire ooo_pkg::xword_t    wr1_data,
    input  wire ooo_pkg::arch_reg_t rd_reg,
    output ooo_pkg::xword_t         rd_data
);

    import ooo_pkg::*;

    xword_t regs_q [`OOO_ARCH_REGS];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `OOO_ARCH_REGS; i++)
                regs_q[i] <= '0;
        end else begin
            if (wr0_en)
                regs_q[wr0_reg] <= wr0_data;
            // port 1 is younger, its write lands last
            if (wr1_en)
                regs_q[wr1_reg] <= wr1_data;
        end
    end

    assign rd_data = regs_q[rd_reg];   // async read

endmodule

`default_nettype wire

//--- reorder_buffer.sv
`default_nettype none

`include "ooo_cfg.svh"

module reorder_buffer (
    input  wire logic               clk,
    input  wire logic               rstn,
    // allocation from rename
    input  wire logic               alloc,
    input  wire ooo_pkg::xword_t    alloc_pc,
    input  wire ooo_pkg::arch_reg_t alloc_arch,
    input  wire logic               alloc_has_dest,
    input  wire ooo_pkg::phys_reg_t alloc_new_phys,
    input  wire ooo_pkg::phys_reg_t alloc_old_phys,
    output logic                    rob_space,
    // completion by slot tag
    input  wire logic               cmp_valid,
    input  wire ooo_pkg::rob_tag_t  cmp_tag,
    input  wire ooo_pkg::xword_t    cmp_data,
    // retire slot 0
    output logic                    retire0_valid,
    output ooo_pkg::xword_t         retire0_pc,
    output ooo_pkg::arch_reg_t      retire0_arch,
    output ooo_pkg::xword_t         retire0_data,
    output logic                    retire0_wr,
    output ooo_pkg::phys_reg_t      retire0_new_phys,
    output ooo_pkg::phys_reg_t      retire0_old_phys,
    // retire slot 1, always the younger one
    output logic                    retire1_valid,
    output ooo_pkg::xword_t         retire1_pc,
    output ooo_pkg::arch_reg_t      retire1_arch,
    output ooo_pkg::xword_t         retire1_data,
    output logic                    retire1_wr,
    output ooo_pkg::phys_reg_t      retire1_new_phys,
    output ooo_pkg::phys_reg_t      retire1_old_phys,
    output logic [`OOO_PHYS_REGS-1:0] phys_ready
);

    import ooo_pkg::*;

    localparam int DEPTH = `OOO_ROB_DEPTH;
    localparam int CW    = $clog2(DEPTH + 1);

    rob_entry_t         rob_q [DEPTH];
    logic [DEPTH-1:0]   valid_q;
    logic [DEPTH-1:0]   done_q;
    rob_tag_t           head_q;
    rob_tag_t           tail_q;
    logic [CW-1:0]      count_q;
    rob_tag_t           head1;
    rob_entry_t         e0;
    rob_entry_t         e1;
    logic               do_alloc;
    logic               ret0;
    logic               ret1;
    logic [1:0]         n_ret;

    assign rob_space = (count_q != CW'(DEPTH));
    assign do_alloc  = alloc && rob_space;

    // head and head+1 looked at every cycle
    assign head1 = head_q + 1'b1;          // wraps with the tag width
    assign e0    = rob_q[head_q];
    assign e1    = rob_q[head1];
    assign ret0  = valid_q[head_q] && done_q[head_q];
    assign ret1  = ret0 && valid_q[head1] && done_q[head1];  // in order only
    assign n_ret = {1'b0, ret0} + {1'b0, ret1};

    // entry storage, data filled in by completion
    always_ff @(posedge clk) begin
        if (do_alloc)
            rob_q[tail_q] <= '{pc:       alloc_pc,
                               arch:     alloc_arch,
                               new_phys: alloc_new_phys,
                               old_phys: alloc_old_phys,
                               has_dest: alloc_has_dest,
                               data:     '0};
        if (cmp_valid)
            rob_q[cmp_tag].data <= cmp_data;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q       <= '0;
            done_q        <= '0;
            head_q        <= '0;
            tail_q        <= '0;
            count_q       <= '0;
            phys_ready    <= '1;
            retire0_valid <= 1'b0;
            retire0_wr    <= 1'b0;
            retire1_valid <= 1'b0;
            retire1_wr    <= 1'b0;
        end else begin
            if (do_alloc) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= tail_q + 1'b1;
            end
            if (cmp_valid)
                done_q[cmp_tag] <= 1'b1;

            // retired slots go back to empty, done cleared for reuse
            if (ret0) begin
                valid_q[head_q] <= 1'b0;
                done_q[head_q]  <= 1'b0;
            end
            if (ret1) begin
                valid_q[head1] <= 1'b0;
                done_q[head1]  <= 1'b0;
            end
            head_q  <= head_q + rob_tag_t'(n_ret);
            count_q <= count_q + CW'(do_alloc) - CW'(n_ret);

            // result visible once the registered retire reaches the arch file
            if (retire0_wr)
                phys_ready[retire0_new_phys] <= 1'b1;
            if (retire1_wr)
                phys_ready[retire1_new_phys] <= 1'b1;
            if (do_alloc && alloc_has_dest)
                phys_ready[alloc_new_phys] <= 1'b0;   // pending until retire

            retire0_valid <= ret0;
            retire0_wr    <= ret0 && e0.has_dest;
            retire1_valid <= ret1;
            retire1_wr    <= ret1 && e1.has_dest;
        end
    end

    // retire payload, held between retirements
    always_ff @(posedge clk) begin
        if (ret0) begin
            retire0_pc       <= e0.pc;
            retire0_arch     <= e0.arch;
            retire0_data     <= e0.data;
            retire0_new_phys <= e0.new_phys;
            retire0_old_phys <= e0.old_phys;
        end
        if (ret1) begin
            retire1_pc       <= e1.pc;
            retire1_arch     <= e1.arch;
            retire1_data     <= e1.data;
            retire1_new_phys <= e1.new_phys;
            retire1_old_phys <= e1.old_phys;
        end
    end

endmodule

`default_nettype wire

//--- rename_map.sv
`default_nettype none

`include "ooo_cfg.svh"

module rename_map (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              alloc,
    input  wire ooo_pkg::arch_reg_t alloc_arch,
    input  wire logic              alloc_has_dest,
    output logic                   free_avail,
    output ooo_pkg::phys_reg_t     new_phys,
    output ooo_pkg::phys_reg_t     old_phys,
    input  wire logic              release0_valid,
    input  wire ooo_pkg::phys_reg_t release0_phys,
    input  wire logic              release1_valid,
    input  wire ooo_pkg::phys_reg_t release1_phys
);

    import ooo_pkg::*;

    localparam int ARCH     = `OOO_ARCH_REGS;
    localparam int FL_DEPTH = `OOO_PHYS_REGS - `OOO_ARCH_REGS;
    localparam int FL_AW    = $clog2(FL_DEPTH);

    phys_reg_t          map_q  [ARCH];
    phys_reg_t          free_q [FL_DEPTH];
    logic [FL_AW-1:0]   fl_head;
    logic [FL_AW-1:0]   fl_tail;
    logic [FL_AW:0]     fl_count;
    logic               take;
    logic [1:0]         n_rel;

    assign free_avail = (fl_count != '0);
    assign new_phys   = free_q[fl_head];
    assign old_phys   = map_q[alloc_arch];   // mapping being replaced

    // stores and branches leave the map and free list alone
    assign take  = alloc && alloc_has_dest && free_avail;
    assign n_rel = {1'b0, release0_valid} + {1'b0, release1_valid};

    // list depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < ARCH; i++)
                map_q[i] <= phys_reg_t'(i);          // identity map
            for (int i = 0; i < FL_DEPTH; i++)
                free_q[i] <= phys_reg_t'(ARCH + i);  // upper half free
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= FL_DEPTH[FL_AW:0];
        end else begin
            if (take) begin
                map_q[alloc_arch] <= free_q[fl_head];
                fl_head           <= fl_head + 1'b1;
            end

            // up to two pushes, slot 0 first
            if (release0_valid)
                free_q[fl_tail] <= release0_phys;
            if (release1_valid)
                free_q[fl_tail + FL_AW'(release0_valid)] <= release1_phys;

            fl_tail  <= fl_tail + FL_AW'(n_rel);
            fl_count <= fl_count + (FL_AW + 1)'(n_rel) - (FL_AW + 1)'(take);
        end
    end

endmodule

`default_nettype wire

//--- credit_fifo.sv
`default_nettype none

`include "ooo_cfg.svh"

module credit_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = `OOO_Q_DEPTH
) (
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire logic     in_valid,
    input  wire payload_t in_data,
    output logic          out_valid,
    output payload_t      out_data,
    input  wire logic     pop,
    output logic          credit
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t          mem_q [DEPTH];
    logic [AW-1:0]     rd_ptr;
    logic [AW-1:0]     wr_ptr;
    logic [CW-1:0]     count_q;
    logic              do_pop;

    // wraps at DEPTH-1 so non power of two depths work too
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign out_valid = (count_q != '0);
    assign out_data  = mem_q[rd_ptr];   // head shown combinationally
    assign do_pop    = pop && out_valid; // pop on empty is dropped

    // sender holds a credit per push, so no full check
    always_ff @(posedge clk) begin
        if (in_valid)
            mem_q[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count_q <= '0;
            credit  <= 1'b0;
        end else begin
            if (in_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)
                rd_ptr <= ptr_inc(rd_ptr);
            count_q <= count_q + CW'(in_valid) - CW'(do_pop);
            credit  <= do_pop;          // one pulse per popped entry
        end
    end

endmodule

`default_nettype wire

//--- ooo_pkg.sv
`default_nettype none

`include "ooo_cfg.svh"

package ooo_pkg;

    typedef logic [`OOO_TAG_W-1:0]  rob_tag_t;   // rob slot
    typedef logic [`OOO_AREG_W-1:0] arch_reg_t;
    typedef logic [`OOO_PREG_W-1:0] phys_reg_t;
    typedef logic [`OOO_XLEN-1:0]   xword_t;

    // dispatch channel payload
    typedef struct packed {
        xword_t    pc;
        arch_reg_t arch;
        logic      has_dest;     // low for stores and branches
    } dispatch_pl_t;

    // completion channel payload, tagged by rob slot
    typedef struct packed {
        rob_tag_t tag;
        xword_t   data;
    } complete_pl_t;

    // one rob storage word
    typedef struct packed {
        xword_t    pc;
        arch_reg_t arch;
        phys_reg_t new_phys;
        phys_reg_t old_phys;     // freed at retire
        logic      has_dest;
        xword_t    data;
    } rob_entry_t;

endpackage

`default_nettype wire

//--- ooo_cfg.svh
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// reorder buffer slots, one tag per slot
`define OOO_ROB_DEPTH 64

// architectural and physical register counts
`define OOO_ARCH_REGS 32
`define OOO_PHYS_REGS 64

// data path width
`define OOO_XLEN 32

// receive queue depth, also the sender's starting credit count
`define OOO_Q_DEPTH 4

// index widths derived from the counts above
`define OOO_TAG_W  $clog2(`OOO_ROB_DEPTH)
`define OOO_AREG_W $clog2(`OOO_ARCH_REGS)
`define OOO_PREG_W $clog2(`OOO_PHYS_REGS)

`endif
